// ==== source/id_config.svh ====
// width, register count and reset pc macros for the decode stage
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// data path and pc width
`define ID_XLEN         64

// fetched instruction width
`define ID_INST_WD      32

// general registers
`define ID_GPR_ADDR_WD  5
`define ID_GPR_NUM      32

// pc held by the empty stage register
`define ID_RESET_PC     64'h8000_0000

`endif

// ==== source/id_pkg.sv ====
// opcode, alu op and branch function enums, stage bus structs
`include "id_config.svh"

package id_pkg;

  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP_32     = 7'b0111011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  // values follow funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd4,
    BR_GE  = 3'd5,
    BR_LTU = 3'd6,
    BR_GEU = 3'd7
  } br_func_e;

  typedef struct packed {
    logic [`ID_INST_WD-1:0] inst;
    logic [`ID_XLEN-1:0]    pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic                      wen;
    logic [`ID_GPR_ADDR_WD-1:0] waddr;
    logic [`ID_XLEN-1:0]       wdata;
  } rf_wr_t;

  typedef struct packed {
    logic               taken;
    logic [`ID_XLEN-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic [`ID_GPR_ADDR_WD-1:0] rs1;
    logic [`ID_GPR_ADDR_WD-1:0] rs2;
    logic [`ID_GPR_ADDR_WD-1:0] rd;
    logic [`ID_XLEN-1:0]        imm;
    logic                       alu_src1_pc;   // op1 = pc
    logic                       alu_src2_imm;  // op2 = imm
    logic                       alu_word;      // 32-bit result, sign-extended
    alu_op_e                    alu_op;
    logic                       gpr_wen;
    logic                       mem_ren;
    logic                       mem_wen;
    logic [2:0]                 mem_op;        // funct3
    logic                       is_branch;
    logic                       is_jal;
    logic                       is_jalr;
    br_func_e                   br_func;
    logic                       invalid;
  } decode_t;

  typedef struct packed {
    logic [`ID_XLEN-1:0] rs1data;
    logic [`ID_XLEN-1:0] rs2data;
    logic [`ID_XLEN-1:0] pc;
    decode_t             ctrl;
  } ds_to_es_t;

endpackage

// ==== source/id_decoder.sv ====
// combinational rv64i decoder: register fields, immediates, execute and memory control
`include "id_config.svh"

module id_decoder (
  input  logic [`ID_INST_WD-1:0] i_inst,
  output id_pkg::decode_t        o_dec
);

  logic [6:0]                 opcode;
  logic [2:0]                 funct3;
  logic [6:0]                 funct7;
  logic [`ID_GPR_ADDR_WD-1:0] rs1_f;
  logic [`ID_GPR_ADDR_WD-1:0] rs2_f;
  logic [`ID_GPR_ADDR_WD-1:0] rd_f;
  logic [`ID_XLEN-1:0]        imm_i;
  logic [`ID_XLEN-1:0]        imm_s;
  logic [`ID_XLEN-1:0]        imm_b;
  logic [`ID_XLEN-1:0]        imm_u;
  logic [`ID_XLEN-1:0]        imm_j;
  logic                       bad;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign rs1_f  = i_inst[19:15];
  assign rs2_f  = i_inst[24:20];
  assign rd_f   = i_inst[11:7];

  assign imm_i = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`ID_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(`ID_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`ID_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // funct3 table shared by op, op-imm and the 32-bit forms
  function automatic id_pkg::alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    funct_to_alu = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'd1:    funct_to_alu = id_pkg::ALU_SLL;
      3'd2:    funct_to_alu = id_pkg::ALU_SLT;
      3'd3:    funct_to_alu = id_pkg::ALU_SLTU;
      3'd4:    funct_to_alu = id_pkg::ALU_XOR;
      3'd5:    funct_to_alu = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'd6:    funct_to_alu = id_pkg::ALU_OR;
      default: funct_to_alu = id_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_dec         = '0;
    o_dec.mem_op  = funct3;
    o_dec.br_func = id_pkg::br_func_e'(funct3);
    bad           = 1'b0;
    case (opcode)
      id_pkg::OPC_LUI: begin
        o_dec.rd           = rd_f;
        o_dec.imm          = imm_u;
        o_dec.alu_op       = id_pkg::ALU_PASS_B;
        o_dec.alu_src2_imm = 1'b1;
        o_dec.gpr_wen      = 1'b1;
      end
      id_pkg::OPC_AUIPC: begin
        o_dec.rd           = rd_f;
        o_dec.imm          = imm_u;
        o_dec.alu_src1_pc  = 1'b1;
        o_dec.alu_src2_imm = 1'b1;
        o_dec.gpr_wen      = 1'b1;
      end
      id_pkg::OPC_JAL: begin
        o_dec.rd          = rd_f;
        o_dec.imm         = imm_j;
        o_dec.alu_src1_pc = 1'b1;  // link = pc + 4 in execute
        o_dec.gpr_wen     = 1'b1;
        o_dec.is_jal      = 1'b1;
      end
      id_pkg::OPC_JALR: begin
        o_dec.rs1         = rs1_f;
        o_dec.rd          = rd_f;
        o_dec.imm         = imm_i;
        o_dec.alu_src1_pc = 1'b1;
        o_dec.gpr_wen     = 1'b1;
        o_dec.is_jalr     = 1'b1;
        bad               = funct3 != 3'd0;
      end
      id_pkg::OPC_BRANCH: begin
        o_dec.rs1       = rs1_f;
        o_dec.rs2       = rs2_f;
        o_dec.imm       = imm_b;
        o_dec.alu_op    = id_pkg::ALU_SUB;
        o_dec.is_branch = 1'b1;
        bad             = funct3 inside {3'd2, 3'd3};
      end
      id_pkg::OPC_LOAD: begin
        o_dec.rs1          = rs1_f;
        o_dec.rd           = rd_f;
        o_dec.imm          = imm_i;
        o_dec.alu_src2_imm = 1'b1;
        o_dec.mem_ren      = 1'b1;
        o_dec.gpr_wen      = 1'b1;
        bad                = funct3 == 3'd7;  // no ldu
      end
      id_pkg::OPC_STORE: begin
        o_dec.rs1          = rs1_f;
        o_dec.rs2          = rs2_f;
        o_dec.imm          = imm_s;
        o_dec.alu_src2_imm = 1'b1;
        o_dec.mem_wen      = 1'b1;
        bad                = funct3[2];
      end
      id_pkg::OPC_OP_IMM, id_pkg::OPC_OP_IMM_32: begin
        o_dec.rs1          = rs1_f;
        o_dec.rd           = rd_f;
        o_dec.imm          = imm_i;
        o_dec.alu_src2_imm = 1'b1;
        o_dec.gpr_wen      = 1'b1;
        o_dec.alu_word     = opcode == id_pkg::OPC_OP_IMM_32;
        o_dec.alu_op       = funct_to_alu(funct3, funct3 == 3'd5 && i_inst[30]);
        if (opcode == id_pkg::OPC_OP_IMM) begin
          // 6-bit shamt
          if (funct3 == 3'd1) bad = i_inst[31:26] != 6'b0;
          if (funct3 == 3'd5) bad = !(i_inst[31:26] inside {6'b000000, 6'b010000});
        end else begin
          bad = !(funct3 inside {3'd0, 3'd1, 3'd5}) ||
                (funct3 == 3'd1 && funct7 != 7'b0) ||
                (funct3 == 3'd5 && !(funct7 inside {7'b0000000, 7'b0100000}));
        end
      end
      id_pkg::OPC_OP, id_pkg::OPC_OP_32: begin
        o_dec.rs1      = rs1_f;
        o_dec.rs2      = rs2_f;
        o_dec.rd       = rd_f;
        o_dec.gpr_wen  = 1'b1;
        o_dec.alu_word = opcode == id_pkg::OPC_OP_32;
        o_dec.alu_op   = funct_to_alu(funct3, i_inst[30]);
        bad            = !(funct7 == 7'b0 ||
                           (funct7 == 7'b0100000 && funct3 inside {3'd0, 3'd5}));
        if (opcode == id_pkg::OPC_OP_32 && !(funct3 inside {3'd0, 3'd1, 3'd5})) bad = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    o_dec.invalid = bad;
    if (bad) begin  // nothing may write or redirect
      o_dec.gpr_wen   = 1'b0;
      o_dec.mem_ren   = 1'b0;
      o_dec.mem_wen   = 1'b0;
      o_dec.is_branch = 1'b0;
      o_dec.is_jal    = 1'b0;
      o_dec.is_jalr   = 1'b0;
    end
  end

endmodule

// ==== source/id_gpr_file.sv ====
// general register file: two async read ports, one sync write port, x0 tied to zero
`include "id_config.svh"

module id_gpr_file (
  input  logic                       i_clk,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_raddr1,
  output logic [`ID_XLEN-1:0]        o_rdata1,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_raddr2,
  output logic [`ID_XLEN-1:0]        o_rdata2,
  input  id_pkg::rf_wr_t             i_wr
);

  logic [`ID_XLEN-1:0] regs [`ID_GPR_NUM];

  always_ff @(posedge i_clk) begin
    if (i_wr.wen && i_wr.waddr != '0) begin  // x0 never stored
      regs[i_wr.waddr] <= i_wr.wdata;
    end
  end

  // no same-cycle write bypass
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== source/id_branch_unit.sv ====
// branch compare and jump target for redirecting fetch
`include "id_config.svh"

module id_branch_unit (
  input  logic [`ID_XLEN-1:0] i_rs1data,
  input  logic [`ID_XLEN-1:0] i_rs2data,
  input  logic [`ID_XLEN-1:0] i_pc,
  input  logic [`ID_XLEN-1:0] i_imm,
  input  logic                i_is_branch,
  input  logic                i_is_jal,
  input  logic                i_is_jalr,
  input  id_pkg::br_func_e    i_br_func,
  output id_pkg::br_bus_t     o_br
);

  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                cond;
  logic [`ID_XLEN-1:0] base;
  logic [`ID_XLEN-1:0] sum;

  assign eq   = i_rs1data == i_rs2data;
  assign lt_s = $signed(i_rs1data) < $signed(i_rs2data);
  assign lt_u = i_rs1data < i_rs2data;

  always_comb begin
    case (i_br_func)
      id_pkg::BR_EQ:  cond = eq;
      id_pkg::BR_NE:  cond = !eq;
      id_pkg::BR_LT:  cond = lt_s;
      id_pkg::BR_GE:  cond = !lt_s;
      id_pkg::BR_LTU: cond = lt_u;
      id_pkg::BR_GEU: cond = !lt_u;
      default:        cond = 1'b0;
    endcase
  end

  assign base = i_is_jalr ? i_rs1data : i_pc;
  assign sum  = base + i_imm;

  assign o_br = '{taken:  i_is_jal | i_is_jalr | (i_is_branch & cond),
                  target: {sum[`ID_XLEN-1:1], sum[0] & ~i_is_jalr}};  // jalr clears bit 0

endmodule

// ==== source/id_stage.sv ====
// decode stage top: stage register, valid/allowin handshake, hazard stall, execute bus
`include "id_config.svh"

module id_stage (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  // from fetch
  input  logic                       i_fs_to_ds_valid,
  input  id_pkg::fs_to_ds_t          i_fs_to_ds_bus,
  output logic                       o_ds_allowin,
  // to execute
  output logic                       o_ds_to_es_valid,
  output id_pkg::ds_to_es_t          o_ds_to_es_bus,
  input  logic                       i_es_allowin,
  // writeback port
  input  id_pkg::rf_wr_t             i_ws_to_rf,
  // downstream destinations, 0 = no write
  input  logic [`ID_GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [`ID_GPR_ADDR_WD-1:0] i_ws_rd,
  // to fetch
  output id_pkg::br_bus_t            o_br_bus
);

  logic                ds_valid;
  id_pkg::fs_to_ds_t   ds_bus;   // held inst and pc
  id_pkg::decode_t     dec;
  logic [`ID_XLEN-1:0] rs1data;
  logic [`ID_XLEN-1:0] rs2data;
  id_pkg::br_bus_t     br;
  logic                ds_ready_go;

  function automatic logic rd_hit(input logic [`ID_GPR_ADDR_WD-1:0] rd,
                                  input logic [`ID_GPR_ADDR_WD-1:0] rs1,
                                  input logic [`ID_GPR_ADDR_WD-1:0] rs2);
    rd_hit = (rd != '0) && (rd == rs1 || rd == rs2);
  endfunction

  // stall on any pending write to a source
  assign ds_ready_go = !(rd_hit(i_es_rd, dec.rs1, dec.rs2) ||
                         rd_hit(i_ms_rd, dec.rs1, dec.rs2) ||
                         rd_hit(i_ws_rd, dec.rs1, dec.rs2));

  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_bus.inst <= '0;
      ds_bus.pc   <= `ID_RESET_PC;
    end else if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_bus <= i_fs_to_ds_bus;
    end
  end

  id_decoder u_decoder (
    .i_inst (ds_bus.inst),
    .o_dec  (dec)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (dec.rs1),
    .o_rdata1 (rs1data),
    .i_raddr2 (dec.rs2),
    .o_rdata2 (rs2data),
    .i_wr     (i_ws_to_rf)
  );

  id_branch_unit u_branch_unit (
    .i_rs1data   (rs1data),
    .i_rs2data   (rs2data),
    .i_pc        (ds_bus.pc),
    .i_imm       (dec.imm),
    .i_is_branch (dec.is_branch),
    .i_is_jal    (dec.is_jal),
    .i_is_jalr   (dec.is_jalr),
    .i_br_func   (dec.br_func),
    .o_br        (br)
  );

  // empty or stalled stage never redirects
  assign o_br_bus = '{taken: br.taken && o_ds_to_es_valid, target: br.target};

  assign o_ds_to_es_bus = '{rs1data: rs1data,
                            rs2data: rs2data,
                            pc:      ds_bus.pc,
                            ctrl:    dec};

endmodule

// ==== dv/id_stage_tb.sv ====
// decode stage testbench: clock, reset, stimulus, xorshift, reference decode, assertions, timeout
`include "id_config.svh"

module id_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                       i_clk;
  logic                       i_rst_n;
  logic                       i_fs_to_ds_valid;
  id_pkg::fs_to_ds_t          i_fs_to_ds_bus;
  logic                       o_ds_allowin;
  logic                       o_ds_to_es_valid;
  id_pkg::ds_to_es_t          o_ds_to_es_bus;
  logic                       i_es_allowin;
  id_pkg::rf_wr_t             i_ws_to_rf;
  logic [`ID_GPR_ADDR_WD-1:0] i_es_rd;
  logic [`ID_GPR_ADDR_WD-1:0] i_ms_rd;
  logic [`ID_GPR_ADDR_WD-1:0] i_ws_rd;
  id_pkg::br_bus_t            o_br_bus;

  // reference model of the stage and the register file
  logic                m_valid = 1'b0;
  logic [31:0]         m_inst = '0;
  logic [63:0]         m_pc = `ID_RESET_PC;
  logic [63:0]         m_regs [32] = '{default: '0};
  id_pkg::decode_t     exp_dec;
  logic                exp_hz;
  logic                exp_allowin;
  logic                exp_vld;
  logic                exp_taken;
  logic                exp_ctl;
  logic [63:0]         exp_target;
  logic [63:0]         exp_rs1;
  logic [63:0]         exp_rs2;
  logic [9:0]          exp_flags;
  logic [9:0]          got_flags;

  logic        chk = 1'b0;
  logic        bp_mode = 1'b0;
  logic [31:0] seed = 32'hd3b1;
  logic [63:0] pc_ctr = 64'h1000;
  logic [63:0] sent_q [$];
  logic [63:0] got_q [$];
  int          err_cnt = 0;
  int          test_start = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          cycles = 0;

  id_stage dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // about 400 cycles used
  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= 2000) begin
      $display("timeout: run did not finish within 2000 cycles");
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] xs();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic id_pkg::decode_t ref_decode(input logic [31:0] inst);
    id_pkg::decode_t d;
    logic [63:0]     imm_i;
    logic [63:0]     imm_s;
    logic [63:0]     imm_b;
    logic [63:0]     imm_u;
    logic [63:0]     imm_j;
    imm_i = 64'($signed(inst[31:20]));
    imm_s = 64'($signed({inst[31:25], inst[11:7]}));
    imm_b = 64'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
    imm_u = 64'($signed({inst[31:12], 12'h000}));
    imm_j = 64'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
    d = '0;
    d.rs1 = inst[19:15];
    d.rs2 = inst[24:20];
    d.rd = inst[11:7];
    d.alu_op = id_pkg::ALU_ADD;
    case (inst[6:0])
      7'h37: begin  // lui
        d.rs1 = '0;
        d.rs2 = '0;
        d.imm = imm_u;
        d.alu_op = id_pkg::ALU_PASS_B;
        d.alu_src2_imm = 1'b1;
        d.gpr_wen = 1'b1;
      end
      7'h13, 7'h03: begin  // addi, ld
        d.rs2 = '0;
        d.imm = imm_i;
        d.alu_src2_imm = 1'b1;
        d.gpr_wen = 1'b1;
        d.mem_ren = inst[6:0] == 7'h03;
        d.mem_op = inst[14:12];
      end
      7'h23: begin
        d.rd = '0;
        d.imm = imm_s;
        d.alu_src2_imm = 1'b1;
        d.mem_wen = 1'b1;
        d.mem_op = inst[14:12];
      end
      7'h33, 7'h3b: begin  // add, addw
        d.gpr_wen = 1'b1;
        d.alu_word = inst[6:0] == 7'h3b;
      end
      7'h63: begin
        d.rd = '0;
        d.imm = imm_b;
        d.is_branch = 1'b1;
      end
      7'h6f: begin
        d.rs1 = '0;
        d.rs2 = '0;
        d.imm = imm_j;
        d.alu_src1_pc = 1'b1;  // link from pc
        d.gpr_wen = 1'b1;
        d.is_jal = 1'b1;
      end
      7'h67: begin
        d.rs2 = '0;
        d.imm = imm_i;
        d.alu_src1_pc = 1'b1;
        d.gpr_wen = 1'b1;
        d.is_jalr = 1'b1;
      end
      default: begin
        d = '0;
        d.invalid = 1'b1;
      end
    endcase
    return d;
  endfunction

  function automatic logic stall_hit(input logic [4:0] rd, input id_pkg::decode_t d);
    return rd != 5'd0 && (rd == d.rs1 || rd == d.rs2);
  endfunction

  // src1_pc, src2_imm, word, wen, ren, mem wen, branch, jal, jalr, invalid
  function automatic logic [9:0] flag_bits(input id_pkg::decode_t d);
    return {d.alu_src1_pc, d.alu_src2_imm, d.alu_word, d.gpr_wen, d.mem_ren,
            d.mem_wen, d.is_branch, d.is_jal, d.is_jalr, d.invalid};
  endfunction

  always_comb begin
    exp_dec = ref_decode(m_inst);
    exp_rs1 = exp_dec.rs1 == 5'd0 ? 64'd0 : m_regs[exp_dec.rs1];
    exp_rs2 = exp_dec.rs2 == 5'd0 ? 64'd0 : m_regs[exp_dec.rs2];
    exp_hz = stall_hit(i_es_rd, exp_dec) || stall_hit(i_ms_rd, exp_dec) ||
             stall_hit(i_ws_rd, exp_dec);
    exp_allowin = !m_valid || (!exp_hz && i_es_allowin);
    exp_vld = m_valid && !exp_hz;
    exp_ctl = exp_dec.is_branch || exp_dec.is_jal || exp_dec.is_jalr;
    case (m_inst[14:12])
      3'd0:    exp_taken = exp_rs1 == exp_rs2;
      3'd1:    exp_taken = exp_rs1 != exp_rs2;
      3'd4:    exp_taken = $signed(exp_rs1) < $signed(exp_rs2);
      3'd5:    exp_taken = $signed(exp_rs1) >= $signed(exp_rs2);
      3'd6:    exp_taken = exp_rs1 < exp_rs2;
      default: exp_taken = exp_rs1 >= exp_rs2;
    endcase
    exp_taken = exp_dec.is_jal || exp_dec.is_jalr || (exp_dec.is_branch && exp_taken);
    exp_target = exp_dec.is_jalr ? ((exp_rs1 + exp_dec.imm) & ~64'd1) : m_pc + exp_dec.imm;
  end

  assign exp_flags = flag_bits(exp_dec);
  assign got_flags = flag_bits(o_ds_to_es_bus.ctrl);

  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      m_valid <= 1'b0;
      m_inst <= '0;
      m_pc <= `ID_RESET_PC;
    end else if (exp_allowin) begin
      m_valid <= i_fs_to_ds_valid;
      if (i_fs_to_ds_valid) begin
        m_inst <= i_fs_to_ds_bus.inst;
        m_pc <= i_fs_to_ds_bus.pc;
      end
    end
    if (i_ws_to_rf.wen && i_ws_to_rf.waddr != 5'd0) m_regs[i_ws_to_rf.waddr] <= i_ws_to_rf.wdata;
  end

  // pcs reaching execute, sampled late in the cycle
  always @(negedge i_clk) begin
    #40;
    if (chk && o_ds_to_es_valid && i_es_allowin) got_q.push_back(o_ds_to_es_bus.pc);
  end

  task automatic report(input string sig, input logic [63:0] e, input logic [63:0] a);
    $display("[ERROR] %0t %s expected %0h actual %0h", $time, sig, e, a);
    err_cnt++;
  endtask

  a_rst: assert property (@(posedge i_clk) (chk && !i_rst_n) |->
      (!o_ds_to_es_valid && !o_br_bus.taken && o_ds_allowin && o_ds_to_es_bus.pc == `ID_RESET_PC))
    else report("reset {valid, taken, allowin, pc ok}", 64'h3,
                64'({$sampled(o_ds_to_es_valid), $sampled(o_br_bus.taken),
                     $sampled(o_ds_allowin), $sampled(o_ds_to_es_bus.pc) == `ID_RESET_PC}));
  a_allow: assert property (@(posedge i_clk) chk |-> o_ds_allowin == exp_allowin)
    else report("o_ds_allowin", 64'($sampled(exp_allowin)), 64'($sampled(o_ds_allowin)));
  a_valid: assert property (@(posedge i_clk) chk |-> o_ds_to_es_valid == exp_vld)
    else report("o_ds_to_es_valid", 64'($sampled(exp_vld)), 64'($sampled(o_ds_to_es_valid)));
  a_pc: assert property (@(posedge i_clk) (chk && exp_vld) |-> o_ds_to_es_bus.pc == m_pc)
    else report("o_ds_to_es_bus.pc", $sampled(m_pc), $sampled(o_ds_to_es_bus.pc));
  a_rs1: assert property (@(posedge i_clk) (chk && exp_vld) |-> o_ds_to_es_bus.rs1data == exp_rs1)
    else report("rs1data", $sampled(exp_rs1), $sampled(o_ds_to_es_bus.rs1data));
  a_rs2: assert property (@(posedge i_clk) (chk && exp_vld) |-> o_ds_to_es_bus.rs2data == exp_rs2)
    else report("rs2data", $sampled(exp_rs2), $sampled(o_ds_to_es_bus.rs2data));
  a_rs_idx: assert property (@(posedge i_clk) (chk && exp_vld) |->
      {o_ds_to_es_bus.ctrl.rs1, o_ds_to_es_bus.ctrl.rs2} == {exp_dec.rs1, exp_dec.rs2})
    else report("ctrl.rs1/rs2", 64'($sampled({exp_dec.rs1, exp_dec.rs2})),
                64'($sampled({o_ds_to_es_bus.ctrl.rs1, o_ds_to_es_bus.ctrl.rs2})));
  a_imm: assert property (@(posedge i_clk)
      (chk && exp_vld && !exp_dec.invalid) |-> o_ds_to_es_bus.ctrl.imm == exp_dec.imm)
    else report("ctrl.imm", $sampled(exp_dec.imm), $sampled(o_ds_to_es_bus.ctrl.imm));
  a_rd: assert property (@(posedge i_clk) (chk && exp_vld) |-> o_ds_to_es_bus.ctrl.rd == exp_dec.rd)
    else report("ctrl.rd", 64'($sampled(exp_dec.rd)), 64'($sampled(o_ds_to_es_bus.ctrl.rd)));
  a_flags: assert property (@(posedge i_clk) (chk && exp_vld) |-> got_flags == exp_flags)
    else report("ctrl flags", 64'($sampled(exp_flags)), 64'($sampled(got_flags)));
  a_memop: assert property (@(posedge i_clk)
      (chk && exp_vld && (exp_dec.mem_ren || exp_dec.mem_wen)) |->
      o_ds_to_es_bus.ctrl.mem_op == exp_dec.mem_op)
    else report("ctrl.mem_op", 64'($sampled(exp_dec.mem_op)),
                64'($sampled(o_ds_to_es_bus.ctrl.mem_op)));
  a_alu: assert property (@(posedge i_clk) (chk && exp_vld && !exp_ctl && !exp_dec.invalid) |->
      o_ds_to_es_bus.ctrl.alu_op == exp_dec.alu_op)
    else report("ctrl.alu_op", 64'($sampled(exp_dec.alu_op)),
                64'($sampled(o_ds_to_es_bus.ctrl.alu_op)));
  a_taken: assert property (@(posedge i_clk) chk |-> o_br_bus.taken == (exp_vld && exp_taken))
    else report("o_br_bus.taken", 64'($sampled(exp_vld && exp_taken)),
                64'($sampled(o_br_bus.taken)));
  a_target: assert property (@(posedge i_clk) (chk && exp_vld && exp_taken) |->
      o_br_bus.target == exp_target)
    else report("o_br_bus.target", $sampled(exp_target), $sampled(o_br_bus.target));

  task automatic finish_test(input string name);
    if (err_cnt == test_start) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - test_start);
    end
    test_start = err_cnt;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [63:0] data);
    @(negedge i_clk);
    i_ws_to_rf = '{wen: 1'b1, waddr: addr, wdata: data};
    @(negedge i_clk);
    i_ws_to_rf.wen = 1'b0;
  endtask

  // hold the instruction until the stage accepts it
  task automatic send(input logic [31:0] inst);
    logic        acc;
    logic [31:0] t;
    @(negedge i_clk);
    i_fs_to_ds_valid = 1'b1;
    i_fs_to_ds_bus = '{inst: inst, pc: pc_ctr};
    acc = 1'b0;
    while (!acc) begin
      if (bp_mode) begin
        t = xs();
        i_es_allowin = t[1:0] == 2'b00;
      end
      #10;
      acc = o_ds_allowin;
      if (!acc) @(negedge i_clk);
    end
    sent_q.push_back(pc_ctr);
    pc_ctr = pc_ctr + 64'd4;
    @(negedge i_clk);
    i_fs_to_ds_valid = 1'b0;
  endtask

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {7'h00, rs2, rs1, 3'd0, rd, 7'h33};
  endfunction

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    i_rst_n = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds_bus = '0;
    i_es_allowin = 1'b1;
    i_ws_to_rf = '0;
    i_es_rd = '0;
    i_ms_rd = '0;
    i_ws_rd = '0;
    @(negedge i_clk);
    chk = 1'b1;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    finish_test("reset");

    for (int r = 1; r < 32; r++) write_reg(5'(r), {xs(), xs()});
    for (int k = 0; k < 10; k++) begin
      a = xs();
      write_reg(a[4:0] == 5'd0 ? 5'd1 : a[4:0], {xs(), xs()});
    end
    for (int k = 0; k < 10; k++) begin
      a = xs();
      send(enc_add(a[14:10], a[4:0], a[9:5]));
    end
    write_reg(5'd0, 64'hdead_beef);
    send(enc_add(5'd1, 5'd0, 5'd0));
    finish_test("register file");

    for (int k = 0; k < 4; k++) begin
      a = xs();
      b = xs();
      send({b[11:0], a[19:15], 3'd0, a[11:7], 7'h13});  // addi
      send({b[31:12], a[11:7], 7'h37});
      send({b[11:5], a[24:20], a[19:15], 3'd2, b[4:0], 7'h23});  // sw
      send({b[11:0], a[19:15], 3'd3, a[11:7], 7'h03});  // ld
      send({7'h00, a[24:20], a[19:15], 3'd0, a[11:7], 7'h3b});  // addw
      send({a[31:7], 7'h7f});  // unused opcode
    end
    finish_test("decode");

    write_reg(5'd1, 64'd5);
    write_reg(5'd2, 64'd5);
    write_reg(5'd3, -64'sd3);
    write_reg(5'd4, 64'd7);
    send(enc_b(13'd16, 5'd2, 5'd1, 3'd0));
    send(enc_b(13'd16, 5'd4, 5'd1, 3'd0));
    send(enc_b(-13'sd8, 5'd4, 5'd1, 3'd1));
    send(enc_b(-13'sd8, 5'd2, 5'd1, 3'd1));
    send(enc_b(13'd40, 5'd1, 5'd3, 3'd4));  // signed less
    send(enc_b(13'd40, 5'd1, 5'd4, 3'd4));
    send(enc_b(13'd40, 5'd2, 5'd1, 3'd4));
    send(enc_b(13'd64, 5'd1, 5'd3, 3'd7));  // unsigned greater
    send(enc_b(13'd64, 5'd4, 5'd1, 3'd7));
    send(enc_b(13'd64, 5'd2, 5'd1, 3'd7));
    send({1'b1, 10'h200, 1'b0, 8'hff, 5'd5, 7'h6f});  // jal -3072
    send({12'd4, 5'd4, 3'd0, 5'd0, 7'h67});  // jalr clears bit 0
    finish_test("branch");

    @(negedge i_clk);
    i_ms_rd = 5'd5;
    send(enc_add(5'd7, 5'd5, 5'd6));
    repeat (4) @(negedge i_clk);
    i_ms_rd = 5'd0;
    send(enc_add(5'd0, 5'd0, 5'd0));
    repeat (2) @(negedge i_clk);
    finish_test("hazard");

    sent_q.delete();
    got_q.delete();
    bp_mode = 1'b1;
    for (int k = 0; k < 12; k++) send(enc_add(5'd8, 5'd1, 5'd2));
    bp_mode = 1'b0;
    i_es_allowin = 1'b1;
    repeat (3) @(negedge i_clk);
    if (sent_q.size() != got_q.size()) begin
      report("pc count at execute", 64'(sent_q.size()), 64'(got_q.size()));
    end else begin
      foreach (sent_q[k]) if (sent_q[k] != got_q[k]) report("pc at execute", sent_q[k], got_q[k]);
    end
    finish_test("back-pressure");

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/id_pkg.sv
source/id_decoder.sv
source/id_gpr_file.sv
source/id_branch_unit.sv
source/id_stage.sv
dv/id_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module id_stage_tb -o id_stage_sim \
  && ./obj_dir/id_stage_sim | tee /dev/stderr | grep -q "^Regression passed$" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
